// ==== Makefile ====
# Verilator flow for the PCIe PIO target.
VERILATOR ?= verilator
TOP       ?= pcie_pio_tb
FILELIST  ?= pcie_pio.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard verilog/*.sv) $(wildcard test/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== pcie_pio.f ====
verilog/pcie_tlp_pkg.sv
verilog/pio_rx_decoder.sv
verilog/pio_reg_bank.sv
verilog/pio_cpl_builder.sv
verilog/pcie_pio_top.sv
test/host_pio.sv
test/pcie_pio_asserts.sv
test/pcie_pio_tb.sv

// ==== test/host_pio.sv ====
`timescale 1ns/1ps

module host_pio import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	input PCIE_TREADY64    pcie_rx_tready,
	output PCIE_TVALID64   pcie_rx_tvalid,
	output PCIE_TLAST64    pcie_rx_tlast,
	output PCIE_TKEEP64    pcie_rx_tkeep,
	output PCIE_TDATA64    pcie_rx_tdata,
	output PCIE_TUSER64_RX pcie_rx_tuser,

	output logic done
);

localparam int NUM_TLPS = 24;

typedef enum logic [1:0] { K_RD, K_WR, K_IO, K_RD2 } host_kind_e;

typedef struct packed {
	host_kind_e  kind;
	logic        bar_ok;
	logic [1:0]  bank;
	logic [3:0]  reg_no;
	logic [3:0]  be;
	logic [31:0] data;
} tlp_entry_t;

tlp_entry_t script [NUM_TLPS];
int         n_loaded = 0;

task automatic add_tlp(input host_kind_e kind, input logic bar_ok, input logic [1:0] bank,
		input logic [3:0] reg_no, input logic [3:0] be, input logic [31:0] data);
	script[n_loaded] = '{kind, bar_ok, bank, reg_no, be, data};
	n_loaded++;
endtask

// Holds one beat until it has been accepted.
task automatic send_beat(input logic [63:0] data, input logic [7:0] keep,
		input logic last, input logic [21:0] user);
	logic taken;
	pcie_rx_tvalid = 1'b1;
	pcie_rx_tdata = data;
	pcie_rx_tkeep = keep;
	pcie_rx_tlast = last;
	pcie_rx_tuser = user;
	taken = 1'b0;
	while (!taken) begin
		taken = pcie_rx_tready; // Stable until the next edge.
		@(posedge pcie_clk);
		#1;
	end
endtask

task automatic insert_gap();
	pcie_rx_tvalid = 1'b0;
	pcie_rx_tlast = 1'b0;
	@(posedge pcie_clk);
	#1;
endtask

task automatic send_tlp(input int idx);
	tlp_entry_t  e;
	logic [2:0]  fmt;
	logic [4:0]  ftype;
	logic [9:0]  len;
	logic [31:0] dw0;
	logic [31:0] dw1;
	logic [31:0] addr;
	logic [21:0] user;
	e = script[idx];
	fmt = (e.kind == K_WR || e.kind == K_IO) ? 3'b010 : 3'b000;
	ftype = (e.kind == K_IO) ? 5'b00010 : 5'b00000; // IO write is unsupported.
	len = (e.kind == K_RD2) ? 10'd2 : 10'd1;
	dw0 = {fmt, ftype, 14'd0, len};
	dw1 = {8'h0a, idx[7:0], 8'h40 + idx[7:0], 4'h0, e.be};
	addr = {24'hf00000, e.bank, e.reg_no, 2'b00};
	user = e.bar_ok ? 22'h000004 : 22'h000008; // BAR 0 or BAR 1.
	send_beat({dw1, dw0}, 8'hff, 1'b0, user);
	send_beat({e.data, addr}, (fmt == 3'b010) ? 8'hff : 8'h0f, 1'b1, user);
endtask

task automatic load_script();
	add_tlp(K_RD, 1'b1, 2'd0, 4'd0, 4'hf, 32'h0);
	add_tlp(K_RD, 1'b1, 2'd1, 4'd5, 4'hf, 32'h0);
	add_tlp(K_RD, 1'b1, 2'd3, 4'd15, 4'hf, 32'h0);
	add_tlp(K_WR, 1'b1, 2'd0, 4'd1, 4'hf, 32'h11223344);
	add_tlp(K_RD, 1'b1, 2'd0, 4'd1, 4'hf, 32'h0);
	add_tlp(K_WR, 1'b1, 2'd0, 4'd1, 4'b0101, 32'haabbccdd);
	add_tlp(K_RD, 1'b1, 2'd0, 4'd1, 4'hf, 32'h0);
	for (int b = 0; b < 4; b++) begin
		add_tlp(K_WR, 1'b1, b[1:0], 4'd7, 4'hf, {4{4'ha + b[3:0], b[3:0]}});
	end
	for (int b = 0; b < 4; b++) begin
		add_tlp(K_RD, 1'b1, b[1:0], 4'd7, 4'hf, 32'h0);
	end
	add_tlp(K_IO, 1'b1, 2'd2, 4'd7, 4'hf, 32'hdeadbeef);
	add_tlp(K_WR, 1'b0, 2'd1, 4'd7, 4'hf, 32'h0badf00d);
	add_tlp(K_RD, 1'b0, 2'd2, 4'd7, 4'hf, 32'h0);
	add_tlp(K_RD, 1'b1, 2'd2, 4'd7, 4'hf, 32'h0);
	add_tlp(K_RD, 1'b1, 2'd1, 4'd7, 4'hf, 32'h0);
	add_tlp(K_WR, 1'b1, 2'd3, 4'd2, 4'b1100, 32'h55667788);
	add_tlp(K_RD, 1'b1, 2'd3, 4'd2, 4'hf, 32'h0);
	add_tlp(K_RD2, 1'b1, 2'd0, 4'd1, 4'hf, 32'h0);
	add_tlp(K_RD, 1'b1, 2'd0, 4'd0, 4'hf, 32'h0);
endtask

initial begin
	pcie_rx_tvalid = 1'b0;
	pcie_rx_tlast = 1'b0;
	pcie_rx_tkeep = '0;
	pcie_rx_tdata = '0;
	pcie_rx_tuser = '0;
	done = 1'b0;
	load_script();
	wait (sys_rst === 1'b0);
	@(posedge pcie_clk);
	#1;
	for (int i = 0; i < NUM_TLPS; i++) begin
		if (i % 3 == 2) begin
			insert_gap();
		end
		send_tlp(i);
	end
	pcie_rx_tvalid = 1'b0;
	pcie_rx_tlast = 1'b0;
	done = 1'b1;
end

endmodule

// ==== test/pcie_pio_asserts.sv ====
`timescale 1ns/1ps

module pcie_pio_asserts import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	input PCIE_TREADY64   pcie_rx_tready,
	input PCIE_TVALID64   pcie_rx_tvalid,
	input PCIE_TLAST64    pcie_rx_tlast,
	input PCIE_TDATA64    pcie_rx_tdata,
	input PCIE_TUSER64_RX pcie_rx_tuser,

	input PCIE_TREADY64   pcie_tx_tready,
	input PCIE_TVALID64   pcie_tx_tvalid,
	input PCIE_TLAST64    pcie_tx_tlast,
	input PCIE_TKEEP64    pcie_tx_tkeep,
	input PCIE_TDATA64    pcie_tx_tdata
);

logic [31:0] shadow [NUM_BANKS*BANK_REGS];
logic [63:0] exp_cpl [32]; // Expected beat 1 of each CplD.
logic [4:0]  wr_ptr;
logic [4:0]  rd_ptr;
logic [4:0]  outstanding;
logic [1:0]  beat_no;
logic [31:0] hdr_dw0;
logic [31:0] hdr_dw1;
logic        hdr_bar;
logic        hdr_ok;
logic        hdr_rd;
logic        hdr_wr;
logic [5:0]  widx;
logic        rx_beat;
logic        tx_beat;

int unsigned fail_hdr = 0;
int unsigned fail_data = 0;
int unsigned fail_extra = 0;
int unsigned fail_hold = 0;
int unsigned fail_stall = 0;
int unsigned fail_keep = 0;
int unsigned fail_total;

function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] be);
	logic [31:0] res;
	res = old_word;
	for (int b = 0; b < 4; b++) begin
		if (be[b]) begin
			res[8*b +: 8] = new_word[8*b +: 8];
		end
	end
	return res;
endfunction

assign rx_beat = pcie_rx_tvalid & pcie_rx_tready;
assign tx_beat = pcie_tx_tvalid & pcie_tx_tready;
assign hdr_ok = hdr_bar && hdr_dw0[28:24] == 5'b00000 && hdr_dw0[9:0] == 10'd1;
assign hdr_rd = hdr_ok && hdr_dw0[31:29] == 3'b000;
assign hdr_wr = hdr_ok && hdr_dw0[31:29] == 3'b010;
assign widx = pcie_rx_tdata[7:2]; // Bank and register.
assign outstanding = wr_ptr - rd_ptr;
assign fail_total = fail_hdr + fail_data + fail_extra + fail_hold + fail_stall + fail_keep;

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		for (int i = 0; i < NUM_BANKS*BANK_REGS; i++) begin
			shadow[i] <= '0;
		end
		wr_ptr <= '0;
		rd_ptr <= '0;
		beat_no <= '0;
	end else begin
		if (rx_beat) begin
			beat_no <= pcie_rx_tlast ? 2'd0 : ((beat_no == 2'd3) ? 2'd3 : beat_no + 2'd1);
			if (beat_no == 2'd0) begin
				hdr_dw0 <= pcie_rx_tdata[31:0];
				hdr_dw1 <= pcie_rx_tdata[63:32];
				hdr_bar <= pcie_rx_tuser[2];
			end
			if (beat_no == 2'd1 && pcie_rx_tlast && hdr_wr) begin
				shadow[widx] <= merge_bytes(shadow[widx], pcie_rx_tdata[63:32], hdr_dw1[3:0]);
			end
			if (beat_no == 2'd1 && pcie_rx_tlast && hdr_rd) begin
				exp_cpl[wr_ptr] <= {shadow[widx], hdr_dw1[31:16], hdr_dw1[15:8], 1'b0,
					pcie_rx_tdata[6:0]};
				wr_ptr <= wr_ptr + 5'd1;
			end
		end
		if (tx_beat && pcie_tx_tlast && rd_ptr != wr_ptr) begin
			rd_ptr <= rd_ptr + 5'd1;
		end
	end
end

a_cpl_hdr: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	(tx_beat && !pcie_tx_tlast) |->
	pcie_tx_tdata == {COMPLETER_ID, 3'b000, 1'b0, 12'd4, 32'h4a000001})
	else begin
		fail_hdr++;
		$error("** Error at %0t: CplD header DWs wrong, got %h", $time,
			$sampled(pcie_tx_tdata));
	end

a_cpl_data: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	(tx_beat && pcie_tx_tlast) |-> pcie_tx_tdata == exp_cpl[rd_ptr])
	else begin
		fail_data++;
		$error("** Error at %0t: CplD beat 1 got %h, expected %h", $time,
			$sampled(pcie_tx_tdata), $sampled(exp_cpl[rd_ptr]));
	end

a_cpl_expected: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	(tx_beat && pcie_tx_tlast) |-> rd_ptr != wr_ptr)
	else begin
		fail_extra++;
		$error("** Error at %0t: CplD sent with no read outstanding", $time);
	end

a_tx_hold: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	(pcie_tx_tvalid && !pcie_tx_tready) |=> (pcie_tx_tvalid && $stable(pcie_tx_tdata)
	&& $stable(pcie_tx_tlast) && $stable(pcie_tx_tkeep)))
	else begin
		fail_hold++;
		$error("** Error at %0t: stalled CplD beat changed", $time);
	end

a_rx_stall: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	pcie_tx_tvalid |-> !pcie_rx_tready)
	else begin
		fail_stall++;
		$error("** Error at %0t: rx tready high while a CplD is pending", $time);
	end

a_tx_keep: assert property (@(posedge pcie_clk) disable iff (sys_rst)
	pcie_tx_tvalid |-> pcie_tx_tkeep == 8'hff)
	else begin
		fail_keep++;
		$error("** Error at %0t: CplD tkeep is %h", $time, $sampled(pcie_tx_tkeep));
	end

endmodule

bind pcie_pio_top pcie_pio_asserts asserts_i (
	.pcie_clk       (pcie_clk),
	.sys_rst        (sys_rst),
	.pcie_rx_tready (pcie_rx_tready),
	.pcie_rx_tvalid (pcie_rx_tvalid),
	.pcie_rx_tlast  (pcie_rx_tlast),
	.pcie_rx_tdata  (pcie_rx_tdata),
	.pcie_rx_tuser  (pcie_rx_tuser),
	.pcie_tx_tready (pcie_tx_tready),
	.pcie_tx_tvalid (pcie_tx_tvalid),
	.pcie_tx_tlast  (pcie_tx_tlast),
	.pcie_tx_tkeep  (pcie_tx_tkeep),
	.pcie_tx_tdata  (pcie_tx_tdata)
);

// ==== test/pcie_pio_tb.sv ====
`timescale 1ns/1ps

module pcie_pio_tb import pcie_tlp_pkg::*; ();

localparam int TIMEOUT_CYCLES = 24 * 40; // Up to 40 cycles for each of the 24 TLPs.

logic           pcie_clk = 1'b0;
logic           sys_rst;
PCIE_TREADY64   pcie_rx_tready;
PCIE_TVALID64   pcie_rx_tvalid;
PCIE_TLAST64    pcie_rx_tlast;
PCIE_TKEEP64    pcie_rx_tkeep;
PCIE_TDATA64    pcie_rx_tdata;
PCIE_TUSER64_RX pcie_rx_tuser;
PCIE_TREADY64   pcie_tx_tready;
PCIE_TVALID64   pcie_tx_tvalid;
PCIE_TLAST64    pcie_tx_tlast;
PCIE_TKEEP64    pcie_tx_tkeep;
PCIE_TDATA64    pcie_tx_tdata;
logic           host_done;

integer seed;
integer rnd;
int     cycles = 0;
int     timeouts = 0;
int     other_errors = 0;

always #5 pcie_clk = ~pcie_clk;

pcie_pio_top dut_i (
	.pcie_clk       (pcie_clk),
	.sys_rst        (sys_rst),
	.pcie_rx_tready (pcie_rx_tready),
	.pcie_rx_tvalid (pcie_rx_tvalid),
	.pcie_rx_tlast  (pcie_rx_tlast),
	.pcie_rx_tkeep  (pcie_rx_tkeep),
	.pcie_rx_tdata  (pcie_rx_tdata),
	.pcie_rx_tuser  (pcie_rx_tuser),
	.pcie_tx_tready (pcie_tx_tready),
	.pcie_tx_tvalid (pcie_tx_tvalid),
	.pcie_tx_tlast  (pcie_tx_tlast),
	.pcie_tx_tkeep  (pcie_tx_tkeep),
	.pcie_tx_tdata  (pcie_tx_tdata)
);

host_pio host_i (
	.pcie_clk       (pcie_clk),
	.sys_rst        (sys_rst),
	.pcie_rx_tready (pcie_rx_tready),
	.pcie_rx_tvalid (pcie_rx_tvalid),
	.pcie_rx_tlast  (pcie_rx_tlast),
	.pcie_rx_tkeep  (pcie_rx_tkeep),
	.pcie_rx_tdata  (pcie_rx_tdata),
	.pcie_rx_tuser  (pcie_rx_tuser),
	.done           (host_done)
);

task automatic finish_run();
	int unsigned asserts_failed;
	asserts_failed = dut_i.asserts_i.fail_total;
	$display("Run ended: %0d assertion failures, %0d timeouts, %0d other errors",
		asserts_failed, timeouts, other_errors);
	if (asserts_failed == 0 && timeouts == 0 && other_errors == 0) begin
		$display("NO ERRORS");
	end else begin
		$display("ERRORS FOUND");
	end
	$finish;
endtask

initial begin
	sys_rst = 1'b1;
	repeat (10) @(posedge pcie_clk);
	#1;
	sys_rst = 1'b0;
end

// Completer back-pressure with tready high in about 70 percent of cycles.
initial begin
	seed = 32'hf286;
	pcie_tx_tready = 1'b0;
	forever begin
		@(posedge pcie_clk);
		#1;
		rnd = $random(seed);
		pcie_tx_tready = (rnd[3:0] < 4'd11);
	end
end

always @(posedge pcie_clk) begin
	cycles <= cycles + 1;
	if (cycles == TIMEOUT_CYCLES) begin
		timeouts = timeouts + 1;
		$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
		finish_run();
	end
end

initial begin
	logic drained;
	wait (host_done === 1'b1);
	drained = 1'b0;
	while (!drained) begin
		@(posedge pcie_clk);
		#1;
		drained = pcie_rx_tready && !pcie_tx_tvalid; // Last CplD has left.
	end
	repeat (4) @(posedge pcie_clk);
	#1;
	if (dut_i.asserts_i.outstanding != 5'd0) begin
		other_errors = other_errors + 1;
		$display("Missing completions: %0d reads were never answered.",
			dut_i.asserts_i.outstanding);
	end
	finish_run();
end

endmodule

// ==== verilog/pcie_pio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pcie_pio_top import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	output PCIE_TREADY64  pcie_rx_tready,
	input PCIE_TVALID64   pcie_rx_tvalid,
	input PCIE_TLAST64    pcie_rx_tlast,
	input PCIE_TKEEP64    pcie_rx_tkeep,
	input PCIE_TDATA64    pcie_rx_tdata,
	input PCIE_TUSER64_RX pcie_rx_tuser,

	input PCIE_TREADY64   pcie_tx_tready,
	output PCIE_TVALID64  pcie_tx_tvalid,
	output PCIE_TLAST64   pcie_tx_tlast,
	output PCIE_TKEEP64   pcie_tx_tkeep,
	output PCIE_TDATA64   pcie_tx_tdata
);

pio_req_t             req;
logic [NUM_BANKS-1:0] req_stb;
logic                 read_pending;
logic                 cpl_busy;
pio_rsp_t             bank_rsp [NUM_BANKS];
logic [NUM_BANKS-1:0] bank_rsp_stb;

pio_rx_decoder rx_dec_i (
	.pcie_clk       (pcie_clk),
	.sys_rst        (sys_rst),
	.pcie_rx_tready (pcie_rx_tready),
	.pcie_rx_tvalid (pcie_rx_tvalid),
	.pcie_rx_tlast  (pcie_rx_tlast),
	.pcie_rx_tkeep  (pcie_rx_tkeep),
	.pcie_rx_tdata  (pcie_rx_tdata),
	.pcie_rx_tuser  (pcie_rx_tuser),
	.cpl_busy       (cpl_busy),
	.req            (req),
	.req_stb        (req_stb),
	.read_pending   (read_pending)
);

for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
	pio_reg_bank bank_i (
		.pcie_clk (pcie_clk),
		.sys_rst  (sys_rst),
		.req      (req),
		.req_stb  (req_stb[i]),
		.rsp      (bank_rsp[i]),
		.rsp_stb  (bank_rsp_stb[i])
	);
end

pio_cpl_builder cpl_i (
	.pcie_clk       (pcie_clk),
	.sys_rst        (sys_rst),
	.rsp            (bank_rsp),
	.rsp_stb        (bank_rsp_stb),
	.read_pending   (read_pending),
	.cpl_busy       (cpl_busy),
	.pcie_tx_tready (pcie_tx_tready),
	.pcie_tx_tvalid (pcie_tx_tvalid),
	.pcie_tx_tlast  (pcie_tx_tlast),
	.pcie_tx_tkeep  (pcie_tx_tkeep),
	.pcie_tx_tdata  (pcie_tx_tdata)
);

endmodule

`default_nettype wire

// ==== verilog/pcie_tlp_pkg.sv ====
package pcie_tlp_pkg;

typedef logic        PCIE_TREADY64;
typedef logic        PCIE_TVALID64;
typedef logic        PCIE_TLAST64;
typedef logic [7:0]  PCIE_TKEEP64;
typedef logic [63:0] PCIE_TDATA64;
typedef logic [21:0] PCIE_TUSER64_RX;

localparam int NUM_BANKS = 4;
localparam int BANK_REGS = 16;
localparam int BANK_W    = $clog2(NUM_BANKS);
localparam int REG_W     = $clog2(BANK_REGS);

localparam int TUSER_BAR_LSB = 2; // bar_hit is tuser[8:2].

localparam logic [2:0] FMT_3DW_NODATA = 3'b000;
localparam logic [2:0] FMT_3DW_DATA   = 3'b010;
localparam logic [4:0] TYPE_MEM       = 5'b00000;
localparam logic [4:0] TYPE_CPL       = 5'b01010;

localparam logic [2:0]  CPL_STATUS_SC  = 3'd0;
localparam logic [15:0] COMPLETER_ID   = 16'h0100;
localparam logic [11:0] CPL_BYTE_COUNT = 12'd4;

typedef enum logic [1:0] {
	OP_NONE,
	OP_MRD,
	OP_MWR,
	OP_BAD
} tlp_op_e;

typedef struct packed {
	tlp_op_e           op;
	logic [BANK_W-1:0] bank;
	logic [REG_W-1:0]  reg_idx;
	logic [3:0]        first_be;
	logic [31:0]       wdata;
	logic [15:0]       requester_id;
	logic [7:0]        tag;
	logic [6:0]        lower_addr;
} pio_req_t;

typedef struct packed {
	logic [31:0] rdata;
	logic [15:0] requester_id;
	logic [7:0]  tag;
	logic [6:0]  lower_addr;
} pio_rsp_t;

// Only single-DW 32-bit memory requests are accepted.
function automatic tlp_op_e tlp_classify(input logic [31:0] dw0);
	logic [2:0] fmt;
	logic [4:0] ftype;
	logic [9:0] len;
	fmt = dw0[31:29];
	ftype = dw0[28:24];
	len = dw0[9:0];
	if (len != 10'd1 || ftype != TYPE_MEM) begin
		return OP_BAD;
	end
	if (fmt == FMT_3DW_NODATA) begin
		return OP_MRD;
	end
	if (fmt == FMT_3DW_DATA) begin
		return OP_MWR;
	end
	return OP_BAD;
endfunction

endpackage

// ==== verilog/pio_cpl_builder.sv ====
`default_nettype none
`timescale 1ns/1ps

module pio_cpl_builder import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	input pio_rsp_t              rsp [NUM_BANKS],
	input logic [NUM_BANKS-1:0]  rsp_stb,
	input wire                   read_pending,
	output logic                 cpl_busy,

	input PCIE_TREADY64   pcie_tx_tready,
	output PCIE_TVALID64  pcie_tx_tvalid,
	output PCIE_TLAST64   pcie_tx_tlast,
	output PCIE_TKEEP64   pcie_tx_tkeep,
	output PCIE_TDATA64   pcie_tx_tdata
);

enum logic [1:0] { IDLE, BEAT0, BEAT1 } state;

pio_rsp_t    rsp_sel;
pio_rsp_t    cpl;
logic        any_stb;
logic        busy_q;
logic        xfer;
logic [31:0] dw0;
logic [31:0] dw1;
logic [31:0] dw2;

// Only one read is outstanding, so at most one strobe is set.
always_comb begin
	rsp_sel = '0;
	for (int i = 0; i < NUM_BANKS; i++) begin
		if (rsp_stb[i]) begin
			rsp_sel = rsp[i];
		end
	end
end

assign any_stb = |rsp_stb;

assign dw0 = {FMT_3DW_DATA, TYPE_CPL, 14'd0, 10'd1}; // CplD, length 1.
assign dw1 = {COMPLETER_ID, CPL_STATUS_SC, 1'b0, CPL_BYTE_COUNT};
assign dw2 = {cpl.requester_id, cpl.tag, 1'b0, cpl.lower_addr};

assign pcie_tx_tvalid = (state != IDLE);
assign pcie_tx_tlast = (state == BEAT1);
assign pcie_tx_tkeep = 8'hff;
assign pcie_tx_tdata = (state == BEAT1) ? {cpl.rdata, dw2} : {dw1, dw0};

assign xfer = pcie_tx_tvalid & pcie_tx_tready;
assign cpl_busy = read_pending | busy_q; // Covers the strobe cycle too.

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		state <= IDLE;
	end else begin
		case (state)
		IDLE: begin
			if (any_stb) begin
				state <= BEAT0;
			end
		end
		BEAT0: begin
			if (pcie_tx_tready) begin
				state <= BEAT1;
			end
		end
		BEAT1: begin
			if (pcie_tx_tready) begin
				state <= IDLE;
			end
		end
		default: begin
			state <= IDLE;
		end
		endcase
	end
end

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		busy_q <= 1'b0;
	end else if (read_pending) begin
		busy_q <= 1'b1;
	end else if (xfer && pcie_tx_tlast) begin
		busy_q <= 1'b0;
	end
end

always_ff @(posedge pcie_clk) begin
	if (state == IDLE && any_stb) begin
		cpl <= rsp_sel; // Held until the last beat leaves.
	end
end

endmodule

`default_nettype wire

// ==== verilog/pio_reg_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module pio_reg_bank import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	input pio_req_t   req,
	input wire        req_stb,

	output pio_rsp_t  rsp,
	output logic      rsp_stb
);

logic [31:0] regs [BANK_REGS];
logic        wr_en;
logic        rd_en;

assign wr_en = req_stb && (req.op == OP_MWR);
assign rd_en = req_stb && (req.op == OP_MRD);

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		for (int i = 0; i < BANK_REGS; i++) begin
			regs[i] <= '0;
		end
	end else if (wr_en) begin
		for (int b = 0; b < 4; b++) begin
			if (req.first_be[b]) begin
				regs[req.reg_idx][8*b +: 8] <= req.wdata[8*b +: 8]; // Enabled bytes only.
			end
		end
	end
end

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		rsp_stb <= 1'b0;
	end else begin
		rsp_stb <= rd_en;
	end
end

always_ff @(posedge pcie_clk) begin
	if (rd_en) begin
		rsp.rdata <= regs[req.reg_idx];
		rsp.requester_id <= req.requester_id;
		rsp.tag <= req.tag;
		rsp.lower_addr <= req.lower_addr;
	end
end

endmodule

`default_nettype wire

// ==== verilog/pio_rx_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module pio_rx_decoder import pcie_tlp_pkg::*; (
	input wire pcie_clk,
	input wire sys_rst,

	output PCIE_TREADY64  pcie_rx_tready,
	input PCIE_TVALID64   pcie_rx_tvalid,
	input PCIE_TLAST64    pcie_rx_tlast,
	input PCIE_TKEEP64    pcie_rx_tkeep,
	input PCIE_TDATA64    pcie_rx_tdata,
	input PCIE_TUSER64_RX pcie_rx_tuser,

	input wire cpl_busy,

	output pio_req_t              req,
	output logic [NUM_BANKS-1:0]  req_stb,
	output logic                  read_pending
);

enum logic [1:0] { HDR, ADDR, DRAIN } state;

logic        rx_rdy;
logic        beat;
tlp_op_e     beat_op;
logic        bar_ok;
logic        keep_ok;
logic [31:0] addr;

tlp_op_e     hdr_op;
logic [15:0] hdr_rid;
logic [7:0]  hdr_tag;
logic [3:0]  hdr_be;

assign pcie_rx_tready = rx_rdy & ~cpl_busy; // Stall while a CplD is pending.
assign beat = pcie_rx_tvalid & pcie_rx_tready;
assign beat_op = tlp_classify(pcie_rx_tdata[31:0]);
assign bar_ok = pcie_rx_tuser[TUSER_BAR_LSB];
assign addr = pcie_rx_tdata[31:0];

// A write needs its payload DW valid, a read only the address DW.
assign keep_ok = (hdr_op == OP_MRD) ? &pcie_rx_tkeep[3:0] : &pcie_rx_tkeep;

always_ff @(posedge pcie_clk) begin
	if (sys_rst) begin
		state <= HDR;
		rx_rdy <= 1'b0;
		req_stb <= '0;
		read_pending <= 1'b0;
	end else begin
		rx_rdy <= 1'b1;
		req_stb <= '0;
		read_pending <= 1'b0;
		if (beat) begin
			case (state)
			HDR: begin
				if (!pcie_rx_tlast) begin
					if ((beat_op == OP_MRD || beat_op == OP_MWR) && bar_ok) begin
						state <= ADDR;
					end else begin
						state <= DRAIN; // Unsupported or other BAR.
					end
				end
			end
			ADDR: begin
				if (pcie_rx_tlast) begin
					state <= HDR;
					if (keep_ok) begin
						req_stb[addr[6 +: BANK_W]] <= 1'b1;
						read_pending <= (hdr_op == OP_MRD);
					end
				end else begin
					state <= DRAIN; // Longer than one DW.
				end
			end
			DRAIN: begin
				if (pcie_rx_tlast) begin
					state <= HDR;
				end
			end
			default: begin
				state <= HDR;
			end
			endcase
		end
	end
end

always_ff @(posedge pcie_clk) begin
	if (beat && state == HDR) begin
		hdr_op <= beat_op;
		hdr_rid <= pcie_rx_tdata[63:48];
		hdr_tag <= pcie_rx_tdata[47:40];
		hdr_be <= pcie_rx_tdata[35:32];
	end
	if (beat && state == ADDR) begin
		req.op <= (keep_ok && pcie_rx_tlast) ? hdr_op : OP_NONE;
		req.bank <= addr[6 +: BANK_W];
		req.reg_idx <= addr[2 +: REG_W];
		req.first_be <= hdr_be;
		req.wdata <= pcie_rx_tdata[63:32];
		req.requester_id <= hdr_rid;
		req.tag <= hdr_tag;
		req.lower_addr <= addr[6:0];
	end
end

endmodule

`default_nettype wire
